//--- hw/lsu_pkg.sv
package lsu_pkg;

  //////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////

  typedef logic [31:0] word_t;   // memory or register data word
  typedef logic [31:0] addr_t;   // byte address
  typedef logic [3:0]  be_t;     // one enable per byte lane
  typedef logic [1:0]  lane_t;   // byte offset inside a word

  //////////////////////////////////////////////////
  // access size
  //////////////////////////////////////////////////

  // 2'b11 decodes as a byte access too
  typedef logic [1:0] dtype_t;

  localparam dtype_t DT_WORD = 2'b00;
  localparam dtype_t DT_HALF = 2'b01;
  localparam dtype_t DT_BYTE = 2'b10;

  //////////////////////////////////////////////////
  // memory handshake states
  //////////////////////////////////////////////////

  typedef enum logic [1:0]
  {
    IDLE,                   // nothing outstanding
    WAIT_RVALID,            // granted, rvalid pending, ex moved on
    WAIT_RVALID_EX_STALL,   // granted while ex was stalled
    IDLE_EX_STALL           // rvalid seen, ex still stalled
  } lsu_state_e;

endpackage

//--- hw/lsu_access_if.sv
`timescale 1ns/1ns

// attributes of the access in flight, from request side to load side
interface lsu_access_if
  import lsu_pkg::*;
();

  logic   gnt;        // memory grant
  logic   rvalid;     // memory read valid
  dtype_t dtype;      // access size of the current request
  lane_t  offset;     // byte lane of the address
  logic   sign_ext;   // sign extend load data
  logic   we;         // store when set

  // request side, drives the live attributes
  modport req
  (
    output dtype,
    output offset,
    output sign_ext,
    output we
  );

  // load side, samples attributes at grant and waits for rvalid
  modport load
  (
    input gnt,
    input rvalid,
    input dtype,
    input offset,
    input sign_ext,
    input we
  );

endinterface

//--- hw/lsu_fsm.sv
`timescale 1ns/1ns

module lsu_fsm
  import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  input  logic data_req_ex_i,    // request from ex stage
  input  logic data_gnt_i,       // memory grant
  input  logic data_rvalid_i,    // memory response
  input  logic ex_valid_i,       // ex stage not stalled

  output logic data_req_o,       // request to memory
  output logic lsu_ready_ex_o,   // low stalls ex
  output logic lsu_ready_wb_o,   // low stalls wb
  output logic busy_o
);

  lsu_state_e state_q;
  lsu_state_e state_d;

  //////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////
  // next state and handshake outputs
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      // pass the request through and wait for a grant
      IDLE:
      begin
        data_req_o = data_req_ex_i;
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;   // hold ex until granted
          if (data_gnt_i)
          begin
            if (ex_valid_i)
              state_d = WAIT_RVALID;
            else
              state_d = WAIT_RVALID_EX_STALL;   // ex did not take the grant yet
          end
        end
      end

      // wb waits for the response, a new request may go out with rvalid
      WAIT_RVALID:
      begin
        lsu_ready_wb_o = 1'b0;
        if (data_rvalid_i)
        begin
          lsu_ready_wb_o = 1'b1;   // only stall source for wb
          data_req_o     = data_req_ex_i;
          if (data_req_ex_i && data_gnt_i)
          begin
            if (ex_valid_i)
              state_d = WAIT_RVALID;
            else
              state_d = WAIT_RVALID_EX_STALL;
          end
          else
          begin
            lsu_ready_ex_o = !data_req_ex_i;   // pending request keeps ex held
            state_d        = IDLE;
          end
        end
      end

      // ex still shows the old request, so nothing is issued here
      WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
        begin
          if (ex_valid_i)
            state_d = IDLE;
          else
            state_d = IDLE_EX_STALL;
        end
        else if (ex_valid_i)
        begin
          state_d = WAIT_RVALID;   // stall gone, continue normally
        end
      end

      // response done, wait for ex to move past the old request
      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  // anything in flight or being asked for
  assign busy_o = (state_q != IDLE) || data_req_o;

endmodule

//--- hw/lsu_req_format.sv
`timescale 1ns/1ns

module lsu_req_format
  import lsu_pkg::*;
(
  input  word_t        operand_a_ex_i,       // base
  input  word_t        operand_b_ex_i,       // increment
  input  logic         addr_useincr_ex_i,    // a + b when set, a alone otherwise
  input  logic         data_we_ex_i,
  input  logic         data_sign_ext_ex_i,
  input  logic         data_req_ex_i,
  input  dtype_t       data_type_ex_i,
  input  word_t        data_wdata_ex_i,      // store data, lane 0 aligned

  output addr_t        data_addr_o,
  output be_t          data_be_o,
  output word_t        data_wdata_o,         // store data on its byte lanes
  output logic         data_misaligned_o,    // to controller

  lsu_access_if.req    acc
);

  addr_t addr_int;
  lane_t offset;
  be_t   be_base;   // enables for the access at lane 0

  //////////////////////////////////////////////////
  // address
  //////////////////////////////////////////////////

  assign addr_int = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign offset   = addr_int[1:0];

  assign data_addr_o = addr_int;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_ex_i)
      DT_WORD: be_base = 4'b1111;
      DT_HALF: be_base = 4'b0011;
      default: be_base = 4'b0001;   // DT_BYTE and code 11
    endcase
  end

  // lanes shifted past lane 3 fall off, first part only
  assign data_be_o = be_base << offset;

  // rotate left so lane 0 of the store data lands on the address lane
  always_comb
  begin
    case (offset)
      2'b00:   data_wdata_o = data_wdata_ex_i;
      2'b01:   data_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'b10:   data_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: data_wdata_o = {data_wdata_ex_i[7:0],  data_wdata_ex_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////
  // word boundary crossing
  //////////////////////////////////////////////////

  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i)
    begin
      case (data_type_ex_i)
        DT_WORD: data_misaligned_o = (offset != 2'b00);   // any nonzero lane
        DT_HALF: data_misaligned_o = (offset == 2'b11);   // upper half spills over
        default: data_misaligned_o = 1'b0;                // bytes never cross
      endcase
    end
  end

  // live attributes, the load side samples them at grant
  assign acc.dtype    = data_type_ex_i;
  assign acc.offset   = offset;
  assign acc.sign_ext = data_sign_ext_ex_i;
  assign acc.we       = data_we_ex_i;

endmodule

//--- hw/lsu_rdata_extract.sv
`timescale 1ns/1ns

module lsu_rdata_extract
  import lsu_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,

  input  word_t         data_rdata_i,      // raw memory word
  lsu_access_if.load    acc,

  output word_t         data_rdata_ex_o    // load result to wb
);

  // attributes of the granted access
  dtype_t      dtype_q;
  lane_t       offset_q;
  logic        sign_ext_q;
  logic        we_q;

  word_t       rdata_shift;   // addressed lane moved down to lane 0
  logic [7:0]  lane_b;
  logic [15:0] lane_h;
  word_t       rdata_ext;     // extended load value
  word_t       rdata_q;       // last load result
  logic        load_done;     // response of a load this cycle

  //////////////////////////////////////////////////
  // capture at grant
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      dtype_q    <= DT_WORD;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (acc.gnt)
    begin
      // rvalid of the previous access is still in this cycle at latest
      dtype_q    <= acc.dtype;
      offset_q   <= acc.offset;
      sign_ext_q <= acc.sign_ext;
      we_q       <= acc.we;
    end
  end

  //////////////////////////////////////////////////
  // lane select and extension
  //////////////////////////////////////////////////

  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};   // offset in bytes
  assign lane_b      = rdata_shift[7:0];
  assign lane_h      = rdata_shift[15:0];   // offset 3 gives a half filled with zeros

  always_comb
  begin
    case (dtype_q)
      DT_WORD: rdata_ext = data_rdata_i;   // words pass unchanged
      DT_HALF: rdata_ext = {{16{sign_ext_q & lane_h[15]}}, lane_h};
      default: rdata_ext = {{24{sign_ext_q & lane_b[7]}}, lane_b};
    endcase
  end

  //////////////////////////////////////////////////
  // result hold
  //////////////////////////////////////////////////

  assign load_done = acc.rvalid && !we_q;   // stores leave the result alone

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (load_done)
      rdata_q <= rdata_ext;
  end

  // live value in the rvalid cycle, held value afterwards
  assign data_rdata_ex_o = load_done ? rdata_ext : rdata_q;

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ns

module lsu_top
  import lsu_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  // memory port
  output logic   data_req_o,
  input  logic   data_gnt_i,
  input  logic   data_rvalid_i,
  output addr_t  data_addr_o,
  output logic   data_we_o,
  output be_t    data_be_o,
  output word_t  data_wdata_o,
  input  word_t  data_rdata_i,

  // ex stage
  input  logic   data_we_ex_i,
  input  dtype_t data_type_ex_i,       // word, half or byte
  input  word_t  data_wdata_ex_i,
  input  logic   data_sign_ext_ex_i,
  output word_t  data_rdata_ex_o,      // load result
  input  logic   data_req_ex_i,
  input  word_t  operand_a_ex_i,
  input  word_t  operand_b_ex_i,
  input  logic   addr_useincr_ex_i,
  output logic   data_misaligned_o,    // to controller

  // pipeline control
  output logic   lsu_ready_ex_o,
  output logic   lsu_ready_wb_o,
  input  logic   ex_valid_i,
  output logic   busy_o
);

  lsu_access_if acc ();

  // memory strobes go straight onto the access bundle
  assign acc.gnt    = data_gnt_i;
  assign acc.rvalid = data_rvalid_i;

  assign data_we_o = acc.we;   // store flag of the live request

  lsu_fsm u_fsm
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  lsu_req_format u_req_format
  (
    .operand_a_ex_i     (operand_a_ex_i),
    .operand_b_ex_i     (operand_b_ex_i),
    .addr_useincr_ex_i  (addr_useincr_ex_i),
    .data_we_ex_i       (data_we_ex_i),
    .data_sign_ext_ex_i (data_sign_ext_ex_i),
    .data_req_ex_i      (data_req_ex_i),
    .data_type_ex_i     (data_type_ex_i),
    .data_wdata_ex_i    (data_wdata_ex_i),
    .data_addr_o        (data_addr_o),
    .data_be_o          (data_be_o),
    .data_wdata_o       (data_wdata_o),
    .data_misaligned_o  (data_misaligned_o),
    .acc                (acc.req)
  );

  lsu_rdata_extract u_rdata_extract
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_rdata_i    (data_rdata_i),
    .acc             (acc.load),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

endmodule

//--- include/tb_lsu_tasks.svh
`ifndef TB_LSU_TASKS_SVH
`define TB_LSU_TASKS_SVH

//////////////////////////////////////////////////
// checking and stimulus helpers
//////////////////////////////////////////////////

task automatic check_value(input string name, input word_t exp, input word_t act);
  assert (act === exp)
  else
  begin
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
    $display("Regression failed");
    $fatal(1, "mismatch");
  end
endtask

// fibonacci lfsr, taps 16 14 13 11, one step per bit
task automatic take_bits(input int n, output logic [31:0] v);
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    v      = {v[30:0], lfsr_q[0]};
  end
endtask

function automatic int size_of(input dtype_t dt);
  if (dt == DT_WORD)
    return 4;
  else if (dt == DT_HALF)
    return 2;
  return 1;   // 11 is a byte too
endfunction

// lanes from the offset up to offset + size, nothing past lane 3
function automatic word_t exp_be(input dtype_t dt, input lane_t off);
  word_t m;
  m = '0;
  for (int i = 0; i < 4; i++)
    if (i >= int'(off) && i < int'(off) + size_of(dt))
      m[i] = 1'b1;
  return m;
endfunction

function automatic word_t exp_wdata(input word_t w, input lane_t off);
  word_t o;
  for (int i = 0; i < 4; i++)
    o[8 * ((i + int'(off)) % 4) +: 8] = w[8 * i +: 8];   // byte i moves up by off
  return o;
endfunction

function automatic word_t exp_load(input word_t raw, input dtype_t dt, input lane_t off,
                                   input logic sext);
  logic [7:0]  b;
  logic [15:0] h;
  b = raw[8 * int'(off) +: 8];
  h = raw[8 * int'(off) +: 16];   // only called with off <= 2 for halves
  if (dt == DT_WORD)
    return raw;
  else if (dt == DT_HALF)
    return sext ? {{16{h[15]}}, h} : {16'b0, h};
  return sext ? {{24{b[7]}}, b} : {24'b0, b};
endfunction

// both wait tasks return at the sample point of the matching cycle
task automatic wait_grant();
  #4;
  while (!(data_req_o && data_gnt_i))
  begin
    @(negedge clk);
    #4;
  end
endtask

// called in WAIT_RVALID, so wb is held until the response
task automatic wait_rvalid();
  #4;
  while (!data_rvalid_i)
  begin
    check_value("rvalid wait ready_wb", 32'h0, {31'b0, lsu_ready_wb_o});
    @(negedge clk);
    #4;
  end
  check_value("rvalid ready_wb", 32'h1, {31'b0, lsu_ready_wb_o});
endtask

task automatic drive_req(input logic we, input dtype_t dt, input lane_t off, input logic sext);
  @(negedge clk);
  operand_a_ex_i     = 32'h0000_1000;
  operand_b_ex_i     = {30'b0, off};
  addr_useincr_ex_i  = 1'b1;
  data_we_ex_i       = we;
  data_type_ex_i     = dt;
  data_sign_ext_ex_i = sext;
  data_wdata_ex_i    = 32'h8C7B_E6A5;
  data_req_ex_i      = 1'b1;
endtask

// full access, returns at the sample point of its rvalid cycle
task automatic run_access(input logic we, input dtype_t dt, input lane_t off, input logic sext);
  drive_req(we, dt, off, sext);
  wait_grant();
  check_value("access addr", 32'h0000_1000 + off, data_addr_o);   // a + b
  check_value("access we", {31'b0, we}, {31'b0, data_we_o});
  @(negedge clk);
  data_req_ex_i = 1'b0;   // ex moves on after the grant
  wait_rvalid();
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic store_format_test();
  word_t w;
  for (int d = 0; d < 3; d++)
    for (int o = 0; o < 4; o++)
    begin
      @(negedge clk);
      w                 = 32'hA1B2_C3D4 ^ {8{4'(o)}};
      operand_a_ex_i    = 32'h0000_2000 + o;   // a alone this time
      operand_b_ex_i    = 32'h0000_0100;       // kept off the address
      addr_useincr_ex_i = 1'b0;
      data_we_ex_i      = 1'b1;
      data_type_ex_i    = dtype_t'(d);
      data_wdata_ex_i   = w;
      #4;
      check_value("store_format addr", 32'h0000_2000 + o, data_addr_o);
      check_value("store_format we", 32'h1, {31'b0, data_we_o});
      check_value("store_format be", exp_be(dtype_t'(d), lane_t'(o)), {28'b0, data_be_o});
      check_value("store_format wdata", exp_wdata(w, lane_t'(o)), data_wdata_o);
    end
endtask

task automatic load_extract_test();
  for (int d = 0; d < 3; d++)
    for (int o = 0; o < 4; o++)
      for (int s = 0; s < 2; s++)
        if (!(d == 0 && o != 0) && !(d == 1 && o == 3))   // legal offsets only
        begin
          run_access(1'b0, dtype_t'(d), lane_t'(o), s[0]);
          check_value("load_extract",
                      exp_load(data_rdata_i, dtype_t'(d), lane_t'(o), s[0]), data_rdata_ex_o);
        end
endtask

task automatic result_hold_test();
  word_t held;
  run_access(1'b0, DT_HALF, 2'd2, 1'b1);
  held = exp_load(data_rdata_i, DT_HALF, 2'd2, 1'b1);
  repeat (3)
  begin
    @(negedge clk);
    #4;
    check_value("result_hold idle", held, data_rdata_ex_o);
  end
  run_access(1'b1, DT_WORD, 2'd0, 1'b0);   // store response leaves it alone
  check_value("result_hold store", held, data_rdata_ex_o);
  @(negedge clk);
  #4;
  check_value("result_hold store", held, data_rdata_ex_o);
endtask

task automatic backpressure_test();
  gnt_hold = 1'b1;
  drive_req(1'b0, DT_WORD, 2'd0, 1'b0);
  repeat (4)
  begin
    @(negedge clk);
    #4;
    check_value("backpressure ready_ex", 32'h0, {31'b0, lsu_ready_ex_o});
    check_value("backpressure req", 32'h1, {31'b0, data_req_o});
    check_value("backpressure addr", 32'h0000_1000, data_addr_o);
  end
  gnt_hold = 1'b0;
  wait_grant();
  @(negedge clk);
  data_req_ex_i = 1'b0;
  wait_rvalid();
  check_value("backpressure busy", 32'h1, {31'b0, busy_o});   // response cycle still busy
  @(negedge clk);
  #4;
  check_value("backpressure busy", 32'h0, {31'b0, busy_o});
endtask

task automatic ex_stall_test();
  int g0;
  g0 = grant_count;
  @(negedge clk);
  ex_valid_i = 1'b0;
  drive_req(1'b0, DT_BYTE, 2'd1, 1'b0);
  wait_grant();
  // req stays high but must not go out again
  @(negedge clk);
  #4;
  while (!data_rvalid_i)
  begin
    check_value("ex_stall req", 32'h0, {31'b0, data_req_o});
    @(negedge clk);
    #4;
  end
  repeat (2)
  begin
    @(negedge clk);
    #4;
    check_value("ex_stall req", 32'h0, {31'b0, data_req_o});
  end
  @(negedge clk);
  ex_valid_i    = 1'b1;
  data_req_ex_i = 1'b0;   // ex retires the stalled access
  #4;
  check_value("ex_stall req", 32'h0, {31'b0, data_req_o});
  check_value("ex_stall grants", 32'(g0 + 1), 32'(grant_count));
endtask

task automatic misaligned_test();
  logic exp;
  gnt_hold = 1'b1;   // flag checks only, no memory traffic
  for (int d = 0; d < 4; d++)
    for (int o = 0; o < 4; o++)
      for (int r = 0; r < 2; r++)
      begin
        @(negedge clk);
        data_type_ex_i    = dtype_t'(d);
        operand_a_ex_i    = 32'h0000_3000 + o;
        addr_useincr_ex_i = 1'b0;
        data_req_ex_i     = r[0];
        exp = r[0] && ((d == 0 && o != 0) || (d == 1 && o == 3));
        #4;
        check_value("misaligned", {31'b0, exp}, {31'b0, data_misaligned_o});
      end
  @(negedge clk);
  data_req_ex_i = 1'b0;
  gnt_hold      = 1'b0;
endtask

`endif

//--- test/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu
  import lsu_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int NUM_TESTS  = 6;
  localparam int CYC_PER_TEST = 200;   // watchdog budget per test

  logic   clk;
  logic   rst_n;

  // memory side, driven by the responder
  logic   data_gnt_i    = 1'b0;
  logic   data_rvalid_i = 1'b0;
  word_t  data_rdata_i  = '0;
  logic   data_req_o;
  addr_t  data_addr_o;
  logic   data_we_o;
  be_t    data_be_o;
  word_t  data_wdata_o;

  // ex stage side, driven by the tests
  logic   data_we_ex_i;
  dtype_t data_type_ex_i;
  word_t  data_wdata_ex_i;
  logic   data_sign_ext_ex_i;
  word_t  data_rdata_ex_o;
  logic   data_req_ex_i;
  word_t  operand_a_ex_i;
  word_t  operand_b_ex_i;
  logic   addr_useincr_ex_i;
  logic   data_misaligned_o;
  logic   lsu_ready_ex_o;
  logic   lsu_ready_wb_o;
  logic   ex_valid_i;
  logic   busy_o;

  logic [15:0] lfsr_q = 16'd29;   // seed
  logic   gnt_hold = 1'b0;        // test withholds the grant
  logic   acc_q    = 1'b0;        // request accepted at last edge
  logic   req_q    = 1'b0;
  int     gnt_wait = -1;          // idle cycles left before grant, -1 when not drawn
  int     rv_delay = 0;           // falling edges left until rvalid
  int     grant_count = 0;

  lsu_top UUT (.*);

  `include "tb_lsu_tasks.svh"

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // memory responder
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    acc_q <= data_req_o && data_gnt_i;
    req_q <= data_req_o;
    if (data_req_o && data_gnt_i)
      grant_count <= grant_count + 1;
  end

  always @(negedge clk)
  begin : responder
    logic [31:0] r;
    logic        rv_now;
    logic        gnt_now;
    rv_now  = 1'b0;
    gnt_now = 1'b0;
    if (rst_n)
    begin
      if (acc_q)
      begin
        take_bits(1, r);
        rv_delay = 1 + int'(r);   // rvalid 1 or 2 cycles after grant
      end
      if (rv_delay != 0)
      begin
        rv_delay--;
        rv_now = (rv_delay == 0);
      end
      if (rv_now)
      begin
        take_bits(32, r);
        data_rdata_i <= r;
      end
      // one access outstanding at a time
      if (req_q && !acc_q && !data_gnt_i && !gnt_hold && rv_delay == 0 && !rv_now)
      begin
        if (gnt_wait < 0)
        begin
          take_bits(2, r);
          gnt_wait = int'(r);   // 0..3 idle cycles
        end
        if (gnt_wait == 0)
        begin
          gnt_now  = 1'b1;
          gnt_wait = -1;
        end
        else
          gnt_wait--;
      end
    end
    data_rvalid_i <= rv_now;
    data_gnt_i    <= gnt_now;
  end

  // watchdog
  initial
  begin
    #(NUM_TESTS * CYC_PER_TEST * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("Regression failed");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    rst_n              = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = DT_WORD;
    data_wdata_ex_i    = '0;
    data_sign_ext_ex_i = 1'b0;
    data_req_ex_i      = 1'b0;
    operand_a_ex_i     = '0;
    operand_b_ex_i     = '0;
    addr_useincr_ex_i  = 1'b0;
    ex_valid_i         = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #4;
    check_value("reset", 32'h1, {31'b0, !busy_o && lsu_ready_ex_o && lsu_ready_wb_o});
    check_value("reset", 32'h0, data_rdata_ex_o);   // hold register cleared

    store_format_test();
    load_extract_test();
    result_hold_test();
    backpressure_test();
    ex_stall_test();
    misaligned_test();

    $display("Regression passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
hw/lsu_pkg.sv
hw/lsu_access_if.sv
hw/lsu_fsm.sv
hw/lsu_req_format.sv
hw/lsu_rdata_extract.sv
hw/lsu_top.sv
test/tb_lsu.sv

//--- Makefile
# build and run the lsu regression with Verilator

OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f compile.f --top-module tb_lsu -Mdir $(OBJ_DIR) -o tb_lsu_sim

run: build
	./$(OBJ_DIR)/tb_lsu_sim

lint:
	verilator --lint-only --timing -f compile.f --top-module tb_lsu
	verilator --lint-only -f compile.f --top-module lsu_top --exclude tb_lsu.sv hw/lsu_top.sv

clean:
	rm -rf $(OBJ_DIR)
